/* common/npc_cfg_pkg.sv */
package npc_cfg_pkg;

  // integer register and memory word width
  localparam int XLEN = 64;

  // byte address width on every bus
  localparam int ADDR_W = 32;

  // one strobe bit per byte of a word
  localparam int MASK_W = 8;

  // rv instructions are 32 bits, two per memory word
  localparam int INST_W = 32;

  // byte offset bits inside a memory word
  localparam int OFF_W = $clog2(MASK_W);

  // memory depth in 64-bit words
  localparam int MEM_WORDS = 1024;
  localparam int MEM_IDX_W = $clog2(MEM_WORDS);

  // cycles from accepted read valid to read ready
  localparam int MEM_RD_LAT = 2;
  localparam int LAT_CNT_W = $clog2(MEM_RD_LAT + 1);

  // first fetch after reset
  localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_0000;

endpackage

/* common/mem_bus_pkg.sv */
package mem_bus_pkg;

  import npc_cfg_pkg::*;

  // read request, held with its valid until ready
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [MASK_W-1:0] rmask;
  } rd_req_t;

  // read data, meaningful only while ready is high
  typedef struct packed {
    logic [XLEN-1:0] rdata;
  } rd_rsp_t;

  // write request, committed on the ready edge
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [MASK_W-1:0] wmask;
    logic [XLEN-1:0]   wdata;
  } wr_req_t;

  typedef enum logic {
    LSU_LOAD,
    LSU_STORE
  } lsu_op_e;

  // access size, byte to dword
  typedef enum logic [1:0] {
    SZ_B,
    SZ_H,
    SZ_W,
    SZ_D
  } lsu_size_e;

  // command into the load/store unit
  typedef struct packed {
    lsu_op_e           op;
    lsu_size_e         size;
    logic              unsigned_ld;
    logic [ADDR_W-1:0] addr;
    logic [XLEN-1:0]   wdata;
  } lsu_req_t;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_IF_READ,
    ARB_MEM_READ
  } arb_state_e;

  typedef enum logic [1:0] {
    FE_REQ,
    FE_WAIT,
    FE_HOLD
  } fetch_state_e;

  typedef enum logic [1:0] {
    LS_IDLE,
    LS_READ,
    LS_WRITE,
    LS_RESP
  } lsu_state_e;

endpackage

/* design/axi_arb.sv */
`timescale 1ns/1ps

// one read port shared by fetch and load/store
// fetch wins when both ask in the same cycle
// the grant is held until the memory answers
module axi_arb
  import mem_bus_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n_i,
  // fetch read side
  input  logic    if_req_valid_i,
  input  rd_req_t if_req_i,
  output logic    if_rsp_ready_o,
  output rd_rsp_t if_rsp_o,
  // load/store read side
  input  logic    mem_req_valid_i,
  input  rd_req_t mem_req_i,
  output logic    mem_rsp_ready_o,
  output rd_rsp_t mem_rsp_o,
  // load/store write side, exclusive
  input  logic    wr_valid_i,
  input  wr_req_t wr_req_i,
  output logic    wr_ready_o,
  // towards memory, read channel
  output logic    arb_req_valid_o,
  output rd_req_t arb_req_o,
  input  logic    arb_rsp_ready_i,
  input  rd_rsp_t arb_rsp_i,
  // towards memory, write channel
  output logic    arb_wr_valid_o,
  output wr_req_t arb_wr_req_o,
  input  logic    arb_wr_ready_i
);

  arb_state_e state_q;

  // request of the winning side
  rd_req_t req_q;

  logic if_granted;
  logic mem_granted;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ARB_IDLE;
    end else begin
      case (state_q)
        ARB_IDLE: begin
          // fixed priority, fetch first
          if (if_req_valid_i) begin
            state_q <= ARB_IF_READ;
          end else if (mem_req_valid_i) begin
            state_q <= ARB_MEM_READ;
          end
        end
        ARB_IF_READ, ARB_MEM_READ: begin
          // release on the read ready, regrant next edge at the earliest
          if (arb_rsp_ready_i) begin
            state_q <= ARB_IDLE;
          end
        end
        default: begin
          state_q <= ARB_IDLE;
        end
      endcase
    end
  end

  // latch the winner's request in the grant edge
  always_ff @(posedge clk) begin
    if (state_q == ARB_IDLE) begin
      req_q <= if_req_valid_i ? if_req_i : mem_req_i;
    end
  end

  assign if_granted  = (state_q == ARB_IF_READ);
  assign mem_granted = (state_q == ARB_MEM_READ);

  // registered grant drives the memory request
  assign arb_req_valid_o = if_granted || mem_granted;
  assign arb_req_o       = req_q;

  // data goes only to the granted side, the other sees zero
  assign if_rsp_ready_o  = if_granted && arb_rsp_ready_i;
  assign if_rsp_o        = if_granted ? arb_rsp_i : '0;
  assign mem_rsp_ready_o = mem_granted && arb_rsp_ready_i;
  assign mem_rsp_o       = mem_granted ? arb_rsp_i : '0;

  // write channel straight through
  assign arb_wr_valid_o = wr_valid_i;
  assign arb_wr_req_o   = wr_req_i;
  assign wr_ready_o     = arb_wr_ready_i;

endmodule

/* design/ifu_fetch.sv */
`timescale 1ns/1ps

// instruction fetch, pc steps by 4
// one instruction buffered at the output
module ifu_fetch
  import npc_cfg_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n_i,
  // redirect from the core
  input  logic              redirect_valid_i,
  input  logic [ADDR_W-1:0] redirect_pc_i,
  // read channel to the arbiter
  output logic              req_valid_o,
  output rd_req_t           req_o,
  input  logic              rsp_ready_i,
  input  rd_rsp_t           rsp_i,
  // instruction out
  output logic              inst_valid_o,
  output logic [INST_W-1:0] inst_o,
  output logic [ADDR_W-1:0] inst_pc_o,
  input  logic              inst_ready_i
);

  fetch_state_e      state_q;
  logic [ADDR_W-1:0] pc_q;
  // pc of the read in flight, stable while valid is up
  logic [ADDR_W-1:0] fetch_addr_q;
  // in-flight read predates a redirect
  logic              stale_q;
  logic              inst_valid_q;
  logic [INST_W-1:0] inst_q;
  logic [ADDR_W-1:0] inst_pc_q;

  logic [ADDR_W-1:0] pc_target;
  logic              drop_rsp;
  logic [INST_W-1:0] rsp_half;

  assign pc_target = redirect_valid_i ? redirect_pc_i : pc_q;
  assign drop_rsp  = stale_q || redirect_valid_i;

  // pc bit 2 picks the upper half of the word
  assign rsp_half = fetch_addr_q[OFF_W-1] ? rsp_i.rdata[XLEN-1 -: INST_W]
                                          : rsp_i.rdata[INST_W-1:0];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // empty hold, leaves for the first fetch
      state_q      <= FE_HOLD;
      pc_q         <= RESET_PC;
      fetch_addr_q <= RESET_PC;
      stale_q      <= 1'b0;
      inst_valid_q <= 1'b0;
    end else begin
      if (redirect_valid_i) begin
        pc_q <= redirect_pc_i;
      end
      case (state_q)
        FE_REQ, FE_WAIT: begin
          if (rsp_ready_i) begin
            stale_q <= 1'b0;
            if (drop_rsp) begin
              // refetch from the new pc
              fetch_addr_q <= pc_target;
              state_q      <= FE_REQ;
            end else begin
              pc_q         <= pc_q + ADDR_W'(4);
              inst_valid_q <= 1'b1;
              state_q      <= FE_HOLD;
            end
          end else begin
            if (redirect_valid_i) begin
              stale_q <= 1'b1;
            end
            state_q <= FE_WAIT;
          end
        end
        FE_HOLD: begin
          // redirect drops the held instruction
          if (redirect_valid_i || !inst_valid_q || inst_ready_i) begin
            inst_valid_q <= 1'b0;
            fetch_addr_q <= pc_target;
            state_q      <= FE_REQ;
          end
        end
        default: begin
          state_q <= FE_HOLD;
        end
      endcase
    end
  end

  // output register, loaded only by a live response
  always_ff @(posedge clk) begin
    if ((state_q != FE_HOLD) && rsp_ready_i && !drop_rsp) begin
      inst_q    <= rsp_half;
      inst_pc_q <= fetch_addr_q;
    end
  end

  assign req_valid_o = (state_q == FE_REQ) || (state_q == FE_WAIT);
  // word aligned, all bytes wanted
  assign req_o.addr  = {fetch_addr_q[ADDR_W-1:OFF_W], OFF_W'(0)};
  assign req_o.rmask = '1;

  assign inst_valid_o = inst_valid_q;
  assign inst_o       = inst_q;
  assign inst_pc_o    = inst_pc_q;

endmodule

/* design/lsu_access.sv */
`timescale 1ns/1ps

// load/store unit, one command at a time
// byte lanes follow address bits 2..0
module lsu_access
  import npc_cfg_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n_i,
  // command in
  input  logic            req_valid_i,
  input  lsu_req_t        req_i,
  output logic            req_ready_o,
  // one-cycle result pulse
  output logic            rsp_valid_o,
  output logic [XLEN-1:0] rsp_data_o,
  // read channel to the arbiter
  output logic            rd_valid_o,
  output rd_req_t         rd_req_o,
  input  logic            rd_ready_i,
  input  rd_rsp_t         rd_rsp_i,
  // write channel
  output logic            wr_valid_o,
  output wr_req_t         wr_req_o,
  input  logic            wr_ready_i
);

  lsu_state_e        state_q;
  lsu_req_t          cmd_q;
  logic [XLEN-1:0]   rsp_data_q;

  logic [OFF_W-1:0]  off;
  logic [MASK_W-1:0] mask;
  logic [XLEN-1:0]   rd_shifted;

  // strobes of an aligned access at offset zero
  function automatic logic [MASK_W-1:0] size_mask(input lsu_size_e size);
    logic [MASK_W-1:0] m;
    case (size)
      SZ_B:    m = MASK_W'(1);
      SZ_H:    m = MASK_W'(3);
      SZ_W:    m = MASK_W'(15);
      default: m = '1;
    endcase
    return m;
  endfunction

  // sign or zero extend from the access size
  function automatic logic [XLEN-1:0] load_ext(
    input logic [XLEN-1:0] word,
    input lsu_size_e       size,
    input logic            uns
  );
    logic [XLEN-1:0] res;
    case (size)
      SZ_B:    res = {{(XLEN-8){~uns & word[7]}}, word[7:0]};
      SZ_H:    res = {{(XLEN-16){~uns & word[15]}}, word[15:0]};
      SZ_W:    res = {{(XLEN-32){~uns & word[31]}}, word[31:0]};
      default: res = word;
    endcase
    return res;
  endfunction

  assign off        = cmd_q.addr[OFF_W-1:0];
  assign mask       = size_mask(cmd_q.size) << off;
  // bring the addressed lane down to bit 0
  assign rd_shifted = rd_rsp_i.rdata >> {off, 3'b000};

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= LS_IDLE;
    end else begin
      case (state_q)
        LS_IDLE: begin
          if (req_valid_i) begin
            state_q <= (req_i.op == LSU_STORE) ? LS_WRITE : LS_READ;
          end
        end
        LS_READ: begin
          if (rd_ready_i) begin
            state_q <= LS_RESP;
          end
        end
        LS_WRITE: begin
          // ready edge is the commit edge
          if (wr_ready_i) begin
            state_q <= LS_RESP;
          end
        end
        default: begin
          state_q <= LS_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == LS_IDLE) && req_valid_i) begin
      cmd_q <= req_i;
    end
    if ((state_q == LS_READ) && rd_ready_i) begin
      rsp_data_q <= load_ext(rd_shifted, cmd_q.size, cmd_q.unsigned_ld);
    end else if ((state_q == LS_WRITE) && wr_ready_i) begin
      // stores answer with zero
      rsp_data_q <= '0;
    end
  end

  assign req_ready_o = (state_q == LS_IDLE);
  assign rsp_valid_o = (state_q == LS_RESP);
  assign rsp_data_o  = rsp_data_q;

  assign rd_valid_o     = (state_q == LS_READ);
  assign rd_req_o.addr  = cmd_q.addr;
  assign rd_req_o.rmask = mask;

  // store data moved up into its lanes
  assign wr_valid_o     = (state_q == LS_WRITE);
  assign wr_req_o.addr  = cmd_q.addr;
  assign wr_req_o.wmask = mask;
  assign wr_req_o.wdata = cmd_q.wdata << {off, 3'b000};

endmodule

/* sram_mem/sram_mem.sv */
`timescale 1ns/1ps

// behavioral sram, 64-bit words
// one read port with fixed latency, one byte-masked write port
module sram_mem
  import npc_cfg_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n_i,
  // read port
  input  logic    rd_valid_i,
  input  rd_req_t rd_req_i,
  output logic    rd_ready_o,
  output rd_rsp_t rd_rsp_o,
  // write port
  input  logic    wr_valid_i,
  input  wr_req_t wr_req_i,
  output logic    wr_ready_o
);

  logic [XLEN-1:0]      mem_q [MEM_WORDS];

  // read countdown, zero means idle
  logic [LAT_CNT_W-1:0] lat_cnt_q;
  logic [XLEN-1:0]      rdata_q;
  logic                 wr_ready_q;

  logic                 rd_accept;
  logic                 wr_commit;
  logic [MEM_IDX_W-1:0] rd_idx;
  logic [MEM_IDX_W-1:0] wr_idx;

  // widen byte strobes to bit strobes
  function automatic logic [XLEN-1:0] expand_mask(input logic [MASK_W-1:0] m);
    logic [XLEN-1:0] bits;
    for (int b = 0; b < MASK_W; b++) begin
      bits[b*8 +: 8] = {8{m[b]}};
    end
    return bits;
  endfunction

  // contents start at zero
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_q[i] = '0;
    end
  end

  // word index from address bits above 2
  assign rd_idx = rd_req_i.addr[MEM_IDX_W+OFF_W-1:OFF_W];
  assign wr_idx = wr_req_i.addr[MEM_IDX_W+OFF_W-1:OFF_W];

  assign rd_accept = rd_valid_i && (lat_cnt_q == '0);
  assign wr_commit = wr_valid_i && wr_ready_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lat_cnt_q  <= '0;
      wr_ready_q <= 1'b0;
    end else begin
      if (rd_accept) begin
        lat_cnt_q <= LAT_CNT_W'(MEM_RD_LAT);
      end else if (lat_cnt_q != '0) begin
        lat_cnt_q <= lat_cnt_q - 1'b1;
      end
      // write ready one cycle after valid, single pulse
      wr_ready_q <= wr_valid_i && !wr_ready_q;
    end
  end

  // read samples at acceptance, so a same-edge write is not seen
  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rdata_q <= mem_q[rd_idx] & expand_mask(rd_req_i.rmask);
    end
    if (wr_commit) begin
      for (int b = 0; b < MASK_W; b++) begin
        if (wr_req_i.wmask[b]) begin
          mem_q[wr_idx][b*8 +: 8] <= wr_req_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // ready in the last count cycle
  assign rd_ready_o     = (lat_cnt_q == LAT_CNT_W'(1));
  assign rd_rsp_o.rdata = rdata_q;
  assign wr_ready_o     = wr_ready_q;

endmodule

/* design/npc_mem_top.sv */
`timescale 1ns/1ps

// memory side of the core
// fetch and load/store share the sram through the arbiter
module npc_mem_top
  import npc_cfg_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n_i,
  // fetch side
  input  logic              redirect_valid_i,
  input  logic [ADDR_W-1:0] redirect_pc_i,
  output logic              inst_valid_o,
  output logic [INST_W-1:0] inst_o,
  output logic [ADDR_W-1:0] inst_pc_o,
  input  logic              inst_ready_i,
  // load/store side
  input  logic              lsu_req_valid_i,
  input  lsu_req_t          lsu_req_i,
  output logic              lsu_req_ready_o,
  output logic              lsu_rsp_valid_o,
  output logic [XLEN-1:0]   lsu_rsp_data_o
);

  // fetch to arbiter
  logic    if_req_valid;
  rd_req_t if_req;
  logic    if_rsp_ready;
  rd_rsp_t if_rsp;

  // load/store to arbiter
  logic    ls_rd_valid;
  rd_req_t ls_rd_req;
  logic    ls_rd_ready;
  rd_rsp_t ls_rd_rsp;
  logic    ls_wr_valid;
  wr_req_t ls_wr_req;
  logic    ls_wr_ready;

  // arbiter to sram
  logic    arb_rd_valid;
  rd_req_t arb_rd_req;
  logic    arb_rd_ready;
  rd_rsp_t arb_rd_rsp;
  logic    arb_wr_valid;
  wr_req_t arb_wr_req;
  logic    arb_wr_ready;

  ifu_fetch ifu_fetch_i (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .req_valid_o      (if_req_valid),
    .req_o            (if_req),
    .rsp_ready_i      (if_rsp_ready),
    .rsp_i            (if_rsp),
    .inst_valid_o     (inst_valid_o),
    .inst_o           (inst_o),
    .inst_pc_o        (inst_pc_o),
    .inst_ready_i     (inst_ready_i)
  );

  lsu_access lsu_access_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_valid_i (lsu_req_valid_i),
    .req_i       (lsu_req_i),
    .req_ready_o (lsu_req_ready_o),
    .rsp_valid_o (lsu_rsp_valid_o),
    .rsp_data_o  (lsu_rsp_data_o),
    .rd_valid_o  (ls_rd_valid),
    .rd_req_o    (ls_rd_req),
    .rd_ready_i  (ls_rd_ready),
    .rd_rsp_i    (ls_rd_rsp),
    .wr_valid_o  (ls_wr_valid),
    .wr_req_o    (ls_wr_req),
    .wr_ready_i  (ls_wr_ready)
  );

  axi_arb axi_arb_i (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .if_req_valid_i  (if_req_valid),
    .if_req_i        (if_req),
    .if_rsp_ready_o  (if_rsp_ready),
    .if_rsp_o        (if_rsp),
    .mem_req_valid_i (ls_rd_valid),
    .mem_req_i       (ls_rd_req),
    .mem_rsp_ready_o (ls_rd_ready),
    .mem_rsp_o       (ls_rd_rsp),
    .wr_valid_i      (ls_wr_valid),
    .wr_req_i        (ls_wr_req),
    .wr_ready_o      (ls_wr_ready),
    .arb_req_valid_o (arb_rd_valid),
    .arb_req_o       (arb_rd_req),
    .arb_rsp_ready_i (arb_rd_ready),
    .arb_rsp_i       (arb_rd_rsp),
    .arb_wr_valid_o  (arb_wr_valid),
    .arb_wr_req_o    (arb_wr_req),
    .arb_wr_ready_i  (arb_wr_ready)
  );

  sram_mem sram_mem_i (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rd_valid_i (arb_rd_valid),
    .rd_req_i   (arb_rd_req),
    .rd_ready_o (arb_rd_ready),
    .rd_rsp_o   (arb_rd_rsp),
    .wr_valid_i (arb_wr_valid),
    .wr_req_i   (arb_wr_req),
    .wr_ready_o (arb_wr_ready)
  );

endmodule

/* tests/npc_mem_assertions.sv */
`timescale 1ns/1ps

// protocol checks bound into npc_mem_top
module npc_mem_assertions
  import npc_cfg_pkg::*;
(
  input logic              clk,
  input logic              rst_n_i,
  input logic              redirect_valid_i,
  input logic              inst_valid_o,
  input logic [INST_W-1:0] inst_o,
  input logic [ADDR_W-1:0] inst_pc_o,
  input logic              inst_ready_i,
  input logic              lsu_req_valid_i,
  input logic              lsu_req_ready_o,
  input logic              lsu_rsp_valid_o,
  // internal handshakes
  input logic              if_req_valid,
  input logic              ls_rd_valid,
  input logic              ls_wr_valid,
  input logic              arb_rd_valid,
  input logic              arb_rd_ready,
  input logic              arb_wr_valid,
  input logic              arb_wr_ready
);

  // load/store command accepted and response not seen yet
  logic busy_q;

  // number of failed assertions
  int fail_cnt = 0;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else if (lsu_req_valid_i && lsu_req_ready_o) begin
      busy_q <= 1'b1;
    end else if (lsu_rsp_valid_o) begin
      busy_q <= 1'b0;
    end
  end

  // quiet while reset is held
  reset_quiet: assert property (@(posedge clk) !rst_n_i |-> !(inst_valid_o
      || lsu_rsp_valid_o || if_req_valid || ls_rd_valid || ls_wr_valid
      || arb_rd_valid || arb_wr_valid || arb_rd_ready || arb_wr_ready))
    else begin
      fail_cnt++;
      $error("valid or ready high during reset");
    end

  // one command at a time
  busy_not_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
      busy_q |-> !lsu_req_ready_o)
    else begin
      fail_cnt++;
      $error("load/store unit ready while a command is outstanding");
    end

  // stalled instruction holds unless a redirect drops it
  inst_held: assert property (@(posedge clk) disable iff (!rst_n_i)
      (inst_valid_o && !inst_ready_i && !redirect_valid_i)
      |=> (inst_valid_o && $stable(inst_o) && $stable(inst_pc_o)))
    else begin
      fail_cnt++;
      $error("stalled instruction changed or vanished");
    end

  rsp_has_cmd: assert property (@(posedge clk) disable iff (!rst_n_i)
      lsu_rsp_valid_o |-> busy_q)
    else begin
      fail_cnt++;
      $error("load/store response without an outstanding command");
    end

endmodule

bind npc_mem_top npc_mem_assertions npc_mem_assertions_i (.*);

/* tests/npc_mem_tb.sv */
`timescale 1ns/1ps

// testbench for the memory side with lsu commands, fetch stream and shadow model
module npc_mem_tb
  import npc_cfg_pkg::*;
  import mem_bus_pkg::*;
();

  localparam int CLK_HALF = 2;
  localparam int RST_CYCLES = 16;
  // one load, store or fetched instruction is one operation
  localparam int TOTAL_OPS = 16 + 56 + 24 + 22 + 16 + 72;
  localparam int WATCHDOG_CYCLES = TOTAL_OPS * 20 + RST_CYCLES;
  localparam logic [ADDR_W-1:0] FETCH_BASE = 32'h0000_1000;
  // fetch stream that runs next to random loads
  localparam logic [ADDR_W-1:0] STREAM_BASE = 32'h0000_0800;
  localparam int STREAM_INSTS = 40;

  logic              clk;
  logic              rst_n_i;
  logic              redirect_valid_i;
  logic [ADDR_W-1:0] redirect_pc_i;
  logic              inst_valid_o;
  logic [INST_W-1:0] inst_o;
  logic [ADDR_W-1:0] inst_pc_o;
  logic              inst_ready_i;
  logic              lsu_req_valid_i;
  lsu_req_t          lsu_req_i;
  logic              lsu_req_ready_o;
  logic              lsu_rsp_valid_o;
  logic [XLEN-1:0]   lsu_rsp_data_o;

  // mirror of the sram contents
  logic [XLEN-1:0]   shadow [MEM_WORDS];
  // pcs still owed by the fetch unit with the oldest in front
  logic [ADDR_W-1:0] exp_pc_q [$];
  string             test_name;
  int                checks;
  int                errors;
  int                err_base;
  int                tests_run;

  npc_mem_top npc_mem_top_i (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .inst_valid_o     (inst_valid_o),
    .inst_o           (inst_o),
    .inst_pc_o        (inst_pc_o),
    .inst_ready_i     (inst_ready_i),
    .lsu_req_valid_i  (lsu_req_valid_i),
    .lsu_req_i        (lsu_req_i),
    .lsu_req_ready_o  (lsu_req_ready_o),
    .lsu_rsp_valid_o  (lsu_rsp_valid_o),
    .lsu_rsp_data_o   (lsu_rsp_data_o)
  );

  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  task automatic check_value(input string what, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  // value checks plus protocol assertion failures
  function automatic int error_count();
    return errors + npc_mem_top_i.npc_mem_assertions_i.fail_cnt;
  endfunction

  // word index of a byte address
  function automatic int word_of(input logic [ADDR_W-1:0] addr);
    return int'(addr[MEM_IDX_W+OFF_W-1:OFF_W]);
  endfunction

  // gather bytes from the shadow and extend from the top byte
  function automatic logic [XLEN-1:0] expect_load(input logic [ADDR_W-1:0] addr,
                                                  input lsu_size_e size, input logic uns);
    int              nbytes;
    int              off;
    logic [XLEN-1:0] word;
    logic [XLEN-1:0] val;
    nbytes = 1 << int'(size);
    off = int'(addr[OFF_W-1:0]);
    word = shadow[word_of(addr)];
    val = '0;
    for (int b = 0; b < nbytes; b++) begin
      val[b*8 +: 8] = word[(off+b)*8 +: 8];
    end
    if (!uns && val[nbytes*8-1]) begin
      for (int b = nbytes; b < MASK_W; b++) begin
        val[b*8 +: 8] = 8'hff;
      end
    end
    return val;
  endfunction

  // store lands in the bytes starting at the address offset
  task automatic shadow_store(input logic [ADDR_W-1:0] addr, input lsu_size_e size,
                              input logic [XLEN-1:0] wdata);
    int nbytes;
    int off;
    nbytes = 1 << int'(size);
    off = int'(addr[OFF_W-1:0]);
    for (int b = 0; b < nbytes; b++) begin
      shadow[word_of(addr)][(off+b)*8 +: 8] = wdata[b*8 +: 8];
    end
  endtask

  function automatic logic [ADDR_W-1:0] rand_word();
    return ADDR_W'($urandom_range(0, MEM_WORDS - 1)) << OFF_W;
  endfunction

  // naturally aligned lane inside the word at base
  function automatic logic [ADDR_W-1:0] rand_lane(input logic [ADDR_W-1:0] base,
                                                  input lsu_size_e size);
    int off;
    off = ($urandom_range(0, MASK_W - 1) >> int'(size)) << int'(size);
    return base | ADDR_W'(off);
  endfunction

  // called and returns on a falling edge
  task automatic lsu_op(input lsu_op_e op, input lsu_size_e size, input logic uns,
                        input logic [ADDR_W-1:0] addr, input logic [XLEN-1:0] wdata);
    lsu_req_t cmd;
    cmd.op = op;
    cmd.size = size;
    cmd.unsigned_ld = uns;
    cmd.addr = addr;
    cmd.wdata = wdata;
    lsu_req_i = cmd;
    lsu_req_valid_i = 1'b1;
    while (!lsu_req_ready_o) begin
      @(negedge clk);
    end
    @(negedge clk);
    lsu_req_valid_i = 1'b0;
    while (!lsu_rsp_valid_o) begin
      @(negedge clk);
    end
    if (op == LSU_STORE) begin
      check_value("store rsp", '0, lsu_rsp_data_o);
      shadow_store(addr, size, wdata);
    end else begin
      check_value("load", expect_load(addr, size, uns), lsu_rsp_data_o);
    end
    @(negedge clk);
  endtask

  task automatic take_inst();
    logic [ADDR_W-1:0] pc;
    logic [XLEN-1:0]   word;
    pc = exp_pc_q.pop_front();
    word = shadow[word_of(pc)];
    check_value("inst pc", XLEN'(pc), XLEN'(inst_pc_o));
    check_value("inst", XLEN'(pc[2] ? word[63:32] : word[31:0]), XLEN'(inst_o));
  endtask

  // redirect and take count instructions in pc order
  task automatic fetch_from(input logic [ADDR_W-1:0] pc, input int count, input bit rand_ready);
    inst_ready_i = 1'b0;
    redirect_valid_i = 1'b1;
    redirect_pc_i = pc;
    @(negedge clk);
    redirect_valid_i = 1'b0;
    for (int i = 0; i < count; i++) begin
      exp_pc_q.push_back(pc + ADDR_W'(4 * i));
    end
    while (exp_pc_q.size() > 0) begin
      inst_ready_i = rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
      // transfer happens at the coming rising edge
      if (inst_valid_o && inst_ready_i) begin
        take_inst();
      end
      @(negedge clk);
    end
    inst_ready_i = 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_base = error_count();
  endtask

  task automatic end_test();
    tests_run++;
    $display("test %s finished, %0d errors", test_name, error_count() - err_base);
  endtask

  initial begin
    logic [ADDR_W-1:0] addr;
    lsu_size_e         size;
    void'($urandom(32'h83fc));
    checks = 0;
    errors = 0;
    tests_run = 0;
    rst_n_i = 1'b1;
    redirect_valid_i = 1'b0;
    redirect_pc_i = '0;
    inst_ready_i = 1'b0;
    lsu_req_valid_i = 1'b0;
    lsu_req_i = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = '0;
    end
    // real falling edge so the async reset fires before the first clock
    #1;
    rst_n_i = 1'b0;
    repeat (RST_CYCLES) @(negedge clk);
    rst_n_i = 1'b1;
    @(negedge clk);

    start_test("dword_store_load");
    repeat (8) begin
      addr = rand_word();
      lsu_op(LSU_STORE, SZ_D, 1'b0, addr, {$urandom, $urandom});
      lsu_op(LSU_LOAD, SZ_D, 1'b0, addr, '0);
    end
    end_test();

    start_test("narrow_load_extend");
    repeat (8) begin
      addr = rand_word();
      lsu_op(LSU_STORE, SZ_D, 1'b0, addr, {$urandom, $urandom});
      for (int s = 0; s < 3; s++) begin
        for (int u = 0; u < 2; u++) begin
          lsu_op(LSU_LOAD, lsu_size_e'(s), 1'(u), rand_lane(addr, lsu_size_e'(s)), '0);
        end
      end
    end
    end_test();

    start_test("narrow_store_mask");
    repeat (8) begin
      addr = rand_word();
      size = lsu_size_e'($urandom_range(0, 1));
      lsu_op(LSU_STORE, SZ_D, 1'b0, addr, {$urandom, $urandom});
      lsu_op(LSU_STORE, size, 1'b0, rand_lane(addr, size), {$urandom, $urandom});
      lsu_op(LSU_LOAD, SZ_D, 1'b0, addr, '0);
    end
    end_test();

    start_test("redirect_fetch");
    // covers every pc fetched from FETCH_BASE in this and the next test
    for (int w = 0; w < 8; w++) begin
      lsu_op(LSU_STORE, SZ_D, 1'b0, FETCH_BASE + ADDR_W'(8 * w), {$urandom, $urandom});
    end
    fetch_from(FETCH_BASE, 8, 1'b0);
    fetch_from(FETCH_BASE + 32'h14, 6, 1'b0);
    end_test();

    start_test("fetch_backpressure");
    fetch_from(FETCH_BASE, 16, 1'b1);
    end_test();

    start_test("fetch_with_loads");
    for (int w = 0; w < STREAM_INSTS / 2; w++) begin
      lsu_op(LSU_STORE, SZ_D, 1'b0, STREAM_BASE + ADDR_W'(8 * w), {$urandom, $urandom});
    end
    fork
      fetch_from(STREAM_BASE, STREAM_INSTS, 1'b0);
      repeat (12) begin
        size = lsu_size_e'($urandom_range(0, 3));
        // loads hit the same words the fetch stream reads
        addr = STREAM_BASE + ADDR_W'(8 * $urandom_range(0, STREAM_INSTS / 2 - 1));
        lsu_op(LSU_LOAD, size, 1'($urandom_range(0, 1)), rand_lane(addr, size), '0);
      end
    join
    end_test();

    $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, error_count());
    if (error_count() == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog sized from the operation count
  initial begin
    #(WATCHDOG_CYCLES * 2 * CLK_HALF);
    $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* all.f */
common/npc_cfg_pkg.sv
common/mem_bus_pkg.sv
design/axi_arb.sv
design/ifu_fetch.sv
design/lsu_access.sv
sram_mem/sram_mem.sv
design/npc_mem_top.sv
tests/npc_mem_assertions.sv
tests/npc_mem_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module npc_mem_tb \
  -f all.f \
  -o npc_mem_sim

# a nonzero exit of the simulation is still judged by its output
sim_out="$(./obj_dir/npc_mem_sim 2>&1)" || true
echo "$sim_out"

if grep -qxF "Done: no errors" <<< "$sim_out"; then
  exit 0
else
  echo "simulation did not report success"
  exit 1
fi
